/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --sv --timing --assert -Wno-fatal
TOP ?= adc_acq_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
rtl/adc_acq_data_pkg.sv
rtl/adc_acq_ctrl_pkg.sv
rtl/adc_acq_sm_cbuf.sv
rtl/adc_circ_buf.sv
rtl/adc_acq_counters.sv
rtl/adc_acq_out_mux.sv
rtl/adc_acq_top.sv
verification/adc_acq_tb.sv

/* rtl/adc_acq_counters.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_acq_counters #(
    parameter int BURSTS_TYPE1 = 2,
    parameter int BURSTS_TYPE2 = 4,
    parameter int BURSTS_TYPE3 = 8
) (
    input  wire logic clk,
    input  wire logic adc_acq_full_reset,
    input  wire adc_acq_ctrl_pkg::fill_type_t fill_type,
    input  wire logic burst_cntr_init,
    input  wire logic burst_cntr_en,
    input  wire logic fill_cntr_en,
    output logic burst_cntr_zero,
    output adc_acq_data_pkg::burst_cnt_t burst_total,
    output adc_acq_data_pkg::fill_num_t fill_cnt
);

    adc_acq_data_pkg::burst_cnt_t burst_cnt;
    adc_acq_data_pkg::burst_cnt_t burst_load;

    // burst count per fill type
    always_comb begin
        case (fill_type)
            2'd1:    burst_load = adc_acq_data_pkg::burst_cnt_t'(BURSTS_TYPE1);
            2'd2:    burst_load = adc_acq_data_pkg::burst_cnt_t'(BURSTS_TYPE2);
            2'd3:    burst_load = adc_acq_data_pkg::burst_cnt_t'(BURSTS_TYPE3);
            default: burst_load = '0;
        endcase
    end

    // zero once the last burst has been counted down
    assign burst_cntr_zero = (burst_cnt == '0);

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cnt <= '0;
            burst_total <= '0;
            fill_cnt <= '0;
        end else begin
            // total kept for the waveform header
            if (burst_cntr_init) begin
                burst_cnt <= burst_load;
                burst_total <= burst_load;
            end else if (burst_cntr_en) begin
                burst_cnt <= burst_cnt - 1'b1;
            end
            if (fill_cntr_en)
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // a fill only starts while armed
    a_init_armed: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        burst_cntr_init |-> fill_type != adc_acq_ctrl_pkg::FILL_DISARMED);

endmodule

`default_nettype wire

/* rtl/adc_acq_ctrl_pkg.sv */
`default_nettype none

package adc_acq_ctrl_pkg;

    // one bit per state, so exactly one bit is set at any time
    typedef enum logic [16:0] {
        IDLE           = 17'h00001,
        WATCH_FOR_TRIG = 17'h00002,
        FILL_INIT1     = 17'h00004,
        FILL_INIT2     = 17'h00008,
        WAVEFORM_INIT1 = 17'h00010,
        WAVEFORM_INIT2 = 17'h00020,
        WAVEFORM_INIT3 = 17'h00040,
        RUN1           = 17'h00080,
        RUN2           = 17'h00100,
        RUN3           = 17'h00200,
        RUN4           = 17'h00400,
        WAVEFORM_TST1  = 17'h00800,
        WAVEFORM_TST2  = 17'h01000,
        CHECKSUM1      = 17'h02000,
        CHECKSUM2      = 17'h04000,
        DDR3_WAIT      = 17'h08000,
        DONE           = 17'h10000
    } acq_state_t;

    // {enable1, enable0}
    typedef logic [1:0] fill_type_t;
    localparam fill_type_t FILL_DISARMED = 2'b00;

endpackage

`default_nettype wire

/* rtl/adc_acq_data_pkg.sv */
`default_nettype none

package adc_acq_data_pkg;

    // one buffer word, two 12-bit samples packed in it
    typedef logic [31:0] adc_word_t;
    // four buffer words, the first one read sits in the low 32 bits
    typedef logic [127:0] adc_burst_t;
    // 1024-word circular buffer
    typedef logic [9:0] cbuf_addr_t;
    // bursts per waveform
    typedef logic [7:0] burst_cnt_t;
    typedef logic [15:0] fill_num_t;

    // tags go in the top byte of the header words
    localparam logic [7:0] FILL_HDR_TAG = 8'hf1;
    localparam logic [7:0] WFM_HDR_TAG = 8'hc5;

    // header field positions, all other bits are zero
    localparam int HDR_TAG_LSB = 120;
    // fill header: fill type above the fill number
    localparam int HDR_TYPE_LSB = 112;
    localparam int HDR_FILL_LSB = 96;
    // waveform header: trigger address above the burst total
    localparam int HDR_ADDR_LSB = 96;
    localparam int HDR_BURSTS_LSB = 80;

endpackage

`default_nettype wire

/* rtl/adc_acq_out_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_acq_out_mux (
    input  wire logic clk,
    input  wire logic adc_acq_full_reset,
    input  wire logic adc_mux_fill_hdr_sel,
    input  wire logic adc_mux_wfm_hdr_sel,
    input  wire logic adc_mux_dat_sel,
    input  wire logic adc_mux_checksum_select,
    input  wire logic adc_mux_checksum_update,
    input  wire logic adc_acq_out_valid,
    input  wire adc_acq_ctrl_pkg::fill_type_t fill_type,
    input  wire adc_acq_data_pkg::fill_num_t fill_cnt,
    input  wire adc_acq_data_pkg::cbuf_addr_t trig_addr,
    input  wire adc_acq_data_pkg::burst_cnt_t burst_total,
    input  wire adc_acq_data_pkg::adc_burst_t burst_dat,
    output adc_acq_data_pkg::adc_burst_t out_dat,
    output logic out_valid
);

    // selection held one cycle, lines up with the valid strobe
    logic fill_hdr_q;
    logic wfm_hdr_q;
    logic dat_q;
    logic checksum_q;
    logic checksum_upd_q;
    adc_acq_data_pkg::adc_burst_t checksum;
    adc_acq_data_pkg::adc_burst_t fill_hdr;
    adc_acq_data_pkg::adc_burst_t wfm_hdr;

    always_comb begin
        fill_hdr = '0;
        fill_hdr[adc_acq_data_pkg::HDR_TAG_LSB +: 8] = adc_acq_data_pkg::FILL_HDR_TAG;
        fill_hdr[adc_acq_data_pkg::HDR_TYPE_LSB +: $bits(fill_type)] = fill_type;
        fill_hdr[adc_acq_data_pkg::HDR_FILL_LSB +: $bits(fill_cnt)] = fill_cnt;
        wfm_hdr = '0;
        wfm_hdr[adc_acq_data_pkg::HDR_TAG_LSB +: 8] = adc_acq_data_pkg::WFM_HDR_TAG;
        wfm_hdr[adc_acq_data_pkg::HDR_ADDR_LSB +: $bits(trig_addr)] = trig_addr;
        wfm_hdr[adc_acq_data_pkg::HDR_BURSTS_LSB +: $bits(burst_total)] = burst_total;
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            {fill_hdr_q, wfm_hdr_q, dat_q, checksum_q, checksum_upd_q} <= '0;
            out_valid <= 1'b0;
        end else begin
            fill_hdr_q <= adc_mux_fill_hdr_sel;
            wfm_hdr_q <= adc_mux_wfm_hdr_sel;
            dat_q <= adc_mux_dat_sel;
            checksum_q <= adc_mux_checksum_select;
            checksum_upd_q <= adc_mux_checksum_update;
            out_valid <= adc_acq_out_valid;
        end
    end

    always_ff @(posedge clk) begin
        // running XOR over the bursts of one fill
        if (adc_mux_fill_hdr_sel)
            checksum <= '0;
        else if (checksum_upd_q)
            checksum <= checksum ^ burst_dat;
        // word held until the next valid
        if (adc_acq_out_valid) begin
            if (fill_hdr_q)
                out_dat <= fill_hdr;
            else if (wfm_hdr_q)
                out_dat <= wfm_hdr;
            else if (dat_q)
                out_dat <= burst_dat;
            else if (checksum_q)
                out_dat <= checksum;
        end
    end

endmodule

`default_nettype wire

/* rtl/adc_acq_sm_cbuf.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_acq_sm_cbuf (
    input  wire logic clk,
    input  wire logic adc_acq_full_reset,
    input  wire logic acq_enable0,
    input  wire logic acq_enable1,
    input  wire logic acq_trig,
    input  wire logic trig_fifo_empty,
    input  wire logic burst_cntr_zero,
    input  wire logic ddr3_wr_done,
    output adc_acq_ctrl_pkg::fill_type_t fill_type,
    output logic trig_pulse,
    output logic trig_addr_rd_en,
    output logic init_circ_buf_rd_addr,
    output logic inc_circ_buf_rd_addr,
    output logic latch_circ_buf_dat,
    output logic burst_cntr_init,
    output logic burst_cntr_en,
    output logic fill_cntr_en,
    output logic adc_mux_fill_hdr_sel,
    output logic adc_mux_wfm_hdr_sel,
    output logic adc_mux_dat_sel,
    output logic adc_mux_checksum_select,
    output logic adc_mux_checksum_update,
    output logic adc_acq_out_valid,
    output logic acq_enabled,
    output logic acq_done,
    output logic sm_idle
);

    // four flops on the enables
    logic [3:0] enable0_sync;
    logic [3:0] enable1_sync;
    // fifth trigger tap gives the edge
    logic [4:0] trig_sync;
    logic [1:0] ddr3_done_sync;
    // armed while either enable is set
    logic mode_enabled;
    adc_acq_ctrl_pkg::acq_state_t cs;
    adc_acq_ctrl_pkg::acq_state_t ns;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            enable0_sync <= '0;
            enable1_sync <= '0;
            trig_sync <= '0;
            ddr3_done_sync <= '0;
            mode_enabled <= 1'b0;
            fill_type <= adc_acq_ctrl_pkg::FILL_DISARMED;
            trig_pulse <= 1'b0;
        end else begin
            enable0_sync <= {enable0_sync[2:0], acq_enable0};
            enable1_sync <= {enable1_sync[2:0], acq_enable1};
            trig_sync <= {trig_sync[3:0], acq_trig};
            ddr3_done_sync <= {ddr3_done_sync[0], ddr3_wr_done};
            mode_enabled <= enable0_sync[3] | enable1_sync[3];
            fill_type <= {enable1_sync[3], enable0_sync[3]};
            // rising edge at the fourth flop, passed only while armed
            trig_pulse <= trig_sync[3] & ~trig_sync[4] & mode_enabled;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset)
            cs <= adc_acq_ctrl_pkg::IDLE;
        else
            cs <= ns;
    end

    always_comb begin
        ns = cs;
        case (cs)
            adc_acq_ctrl_pkg::IDLE:
                if (mode_enabled)
                    ns = adc_acq_ctrl_pkg::WATCH_FOR_TRIG;
            // a queued trigger address starts the fill
            adc_acq_ctrl_pkg::WATCH_FOR_TRIG:
                if (!trig_fifo_empty)
                    ns = adc_acq_ctrl_pkg::FILL_INIT1;
            adc_acq_ctrl_pkg::FILL_INIT1:     ns = adc_acq_ctrl_pkg::FILL_INIT2;
            adc_acq_ctrl_pkg::FILL_INIT2:     ns = adc_acq_ctrl_pkg::WAVEFORM_INIT1;
            adc_acq_ctrl_pkg::WAVEFORM_INIT1: ns = adc_acq_ctrl_pkg::WAVEFORM_INIT2;
            adc_acq_ctrl_pkg::WAVEFORM_INIT2: ns = adc_acq_ctrl_pkg::WAVEFORM_INIT3;
            adc_acq_ctrl_pkg::WAVEFORM_INIT3: ns = adc_acq_ctrl_pkg::RUN1;
            // one buffer word per RUN state
            adc_acq_ctrl_pkg::RUN1:           ns = adc_acq_ctrl_pkg::RUN2;
            adc_acq_ctrl_pkg::RUN2:           ns = adc_acq_ctrl_pkg::RUN3;
            adc_acq_ctrl_pkg::RUN3:           ns = adc_acq_ctrl_pkg::RUN4;
            adc_acq_ctrl_pkg::RUN4:
                if (burst_cntr_zero)
                    ns = adc_acq_ctrl_pkg::WAVEFORM_TST1;
                else
                    ns = adc_acq_ctrl_pkg::RUN1;
            adc_acq_ctrl_pkg::WAVEFORM_TST1:  ns = adc_acq_ctrl_pkg::WAVEFORM_TST2;
            // single waveform per trigger, straight on to the checksum
            adc_acq_ctrl_pkg::WAVEFORM_TST2:  ns = adc_acq_ctrl_pkg::CHECKSUM1;
            adc_acq_ctrl_pkg::CHECKSUM1:      ns = adc_acq_ctrl_pkg::CHECKSUM2;
            adc_acq_ctrl_pkg::CHECKSUM2:      ns = adc_acq_ctrl_pkg::DDR3_WAIT;
            adc_acq_ctrl_pkg::DDR3_WAIT:
                if (ddr3_done_sync[1])
                    ns = adc_acq_ctrl_pkg::DONE;
            // hold here while the trigger stays high, no false retrigger
            adc_acq_ctrl_pkg::DONE:
                if (!(mode_enabled && trig_sync[3]))
                    ns = adc_acq_ctrl_pkg::IDLE;
            default:                          ns = adc_acq_ctrl_pkg::IDLE;
        endcase
    end

    // strobes come from ns, so each is high while its state is current
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            {trig_addr_rd_en, init_circ_buf_rd_addr, inc_circ_buf_rd_addr} <= '0;
            {latch_circ_buf_dat, burst_cntr_init, burst_cntr_en, fill_cntr_en} <= '0;
            {adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel, adc_mux_dat_sel} <= '0;
            {adc_mux_checksum_select, adc_mux_checksum_update} <= '0;
            {adc_acq_out_valid, acq_enabled, acq_done} <= '0;
            sm_idle <= 1'b1;
        end else begin
            sm_idle <= (ns == adc_acq_ctrl_pkg::IDLE);
            // low while idle or waiting, DDR3 may be read then
            acq_enabled <= !(ns inside {adc_acq_ctrl_pkg::IDLE,
                                        adc_acq_ctrl_pkg::WATCH_FOR_TRIG});
            adc_mux_fill_hdr_sel <= (ns == adc_acq_ctrl_pkg::FILL_INIT1);
            // pop the FWFT head into the read counter
            trig_addr_rd_en <= (ns == adc_acq_ctrl_pkg::WAVEFORM_INIT1);
            init_circ_buf_rd_addr <= (ns == adc_acq_ctrl_pkg::WAVEFORM_INIT1);
            burst_cntr_init <= (ns == adc_acq_ctrl_pkg::WAVEFORM_INIT2);
            adc_mux_wfm_hdr_sel <= (ns == adc_acq_ctrl_pkg::WAVEFORM_INIT2);
            // increment in WAVEFORM_INIT3 primes the read one word ahead
            inc_circ_buf_rd_addr <= ns inside {adc_acq_ctrl_pkg::WAVEFORM_INIT3,
                adc_acq_ctrl_pkg::RUN1, adc_acq_ctrl_pkg::RUN2,
                adc_acq_ctrl_pkg::RUN3, adc_acq_ctrl_pkg::RUN4};
            latch_circ_buf_dat <= ns inside {adc_acq_ctrl_pkg::RUN1, adc_acq_ctrl_pkg::RUN2,
                adc_acq_ctrl_pkg::RUN3, adc_acq_ctrl_pkg::RUN4};
            burst_cntr_en <= (ns == adc_acq_ctrl_pkg::RUN1);
            adc_mux_dat_sel <= (ns == adc_acq_ctrl_pkg::RUN3);
            adc_mux_checksum_update <= (ns == adc_acq_ctrl_pkg::RUN3);
            // one valid per header, burst and checksum
            adc_acq_out_valid <= ns inside {adc_acq_ctrl_pkg::FILL_INIT2,
                adc_acq_ctrl_pkg::WAVEFORM_INIT3, adc_acq_ctrl_pkg::RUN4,
                adc_acq_ctrl_pkg::CHECKSUM2};
            adc_mux_checksum_select <= (ns == adc_acq_ctrl_pkg::CHECKSUM1);
            fill_cntr_en <= (ns == adc_acq_ctrl_pkg::CHECKSUM2);
            // pulse on entry only, DONE may last while the trigger is held
            acq_done <= (ns == adc_acq_ctrl_pkg::DONE) && (cs != adc_acq_ctrl_pkg::DONE);
        end
    end

    // state register never holds zero or several states
    a_state_onehot: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        $onehot(cs));

    // mux source is settled one cycle before each valid word
    a_valid_sel_apart: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        adc_acq_out_valid |-> !(adc_mux_fill_hdr_sel || adc_mux_wfm_hdr_sel ||
                                adc_mux_dat_sel || adc_mux_checksum_select));

endmodule

`default_nettype wire

/* rtl/adc_acq_top.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_acq_top #(
    parameter int PRETRIG_WORDS = 16,
    parameter int BURSTS_TYPE1 = 2,
    parameter int BURSTS_TYPE2 = 4,
    parameter int BURSTS_TYPE3 = 8,
    parameter int TFIFO_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic adc_acq_full_reset,
    input  wire logic acq_enable0,
    input  wire logic acq_enable1,
    input  wire logic acq_trig,
    input  wire logic ddr3_wr_done,
    input  wire adc_acq_data_pkg::adc_word_t adc_dat,
    output adc_acq_data_pkg::adc_burst_t out_dat,
    output logic out_valid,
    output logic acq_enabled,
    output logic acq_done,
    output logic sm_idle,
    output adc_acq_data_pkg::fill_num_t fill_cnt
);

    adc_acq_ctrl_pkg::fill_type_t fill_type;
    // sequencer to circular buffer
    logic trig_pulse;
    logic trig_addr_rd_en;
    logic init_circ_buf_rd_addr;
    logic inc_circ_buf_rd_addr;
    logic latch_circ_buf_dat;
    logic trig_fifo_empty;
    adc_acq_data_pkg::cbuf_addr_t trig_addr;
    adc_acq_data_pkg::adc_burst_t burst_dat;
    // sequencer to counters
    logic burst_cntr_init;
    logic burst_cntr_en;
    logic fill_cntr_en;
    logic burst_cntr_zero;
    adc_acq_data_pkg::burst_cnt_t burst_total;
    // sequencer to output mux
    logic adc_mux_fill_hdr_sel;
    logic adc_mux_wfm_hdr_sel;
    logic adc_mux_dat_sel;
    logic adc_mux_checksum_select;
    logic adc_mux_checksum_update;
    logic adc_acq_out_valid;

    adc_acq_sm_cbuf sm_i (
        .clk, .adc_acq_full_reset, .acq_enable0, .acq_enable1, .acq_trig,
        .trig_fifo_empty, .burst_cntr_zero, .ddr3_wr_done, .fill_type, .trig_pulse,
        .trig_addr_rd_en, .init_circ_buf_rd_addr, .inc_circ_buf_rd_addr,
        .latch_circ_buf_dat, .burst_cntr_init, .burst_cntr_en, .fill_cntr_en,
        .adc_mux_fill_hdr_sel, .adc_mux_wfm_hdr_sel, .adc_mux_dat_sel,
        .adc_mux_checksum_select, .adc_mux_checksum_update, .adc_acq_out_valid,
        .acq_enabled, .acq_done, .sm_idle
    );

    adc_circ_buf #(
        .PRETRIG_WORDS(PRETRIG_WORDS),
        .TFIFO_DEPTH(TFIFO_DEPTH)
    ) cbuf_i (
        .clk, .adc_acq_full_reset, .adc_dat, .trig_pulse, .trig_addr_rd_en,
        .init_circ_buf_rd_addr, .inc_circ_buf_rd_addr, .latch_circ_buf_dat,
        .trig_fifo_empty, .trig_addr, .burst_dat
    );

    adc_acq_counters #(
        .BURSTS_TYPE1(BURSTS_TYPE1),
        .BURSTS_TYPE2(BURSTS_TYPE2),
        .BURSTS_TYPE3(BURSTS_TYPE3)
    ) cntr_i (
        .clk, .adc_acq_full_reset, .fill_type, .burst_cntr_init, .burst_cntr_en,
        .fill_cntr_en, .burst_cntr_zero, .burst_total, .fill_cnt
    );

    adc_acq_out_mux mux_i (
        .clk, .adc_acq_full_reset, .adc_mux_fill_hdr_sel, .adc_mux_wfm_hdr_sel,
        .adc_mux_dat_sel, .adc_mux_checksum_select, .adc_mux_checksum_update,
        .adc_acq_out_valid, .fill_type, .fill_cnt, .trig_addr, .burst_total,
        .burst_dat, .out_dat, .out_valid
    );

endmodule

`default_nettype wire

/* rtl/adc_circ_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_circ_buf #(
    parameter int PRETRIG_WORDS = 16,
    parameter int TFIFO_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic adc_acq_full_reset,
    input  wire adc_acq_data_pkg::adc_word_t adc_dat,
    input  wire logic trig_pulse,
    input  wire logic trig_addr_rd_en,
    input  wire logic init_circ_buf_rd_addr,
    input  wire logic inc_circ_buf_rd_addr,
    input  wire logic latch_circ_buf_dat,
    output logic trig_fifo_empty,
    output adc_acq_data_pkg::cbuf_addr_t trig_addr,
    output adc_acq_data_pkg::adc_burst_t burst_dat
);

    localparam int WORD_W = $bits(adc_acq_data_pkg::adc_word_t);
    localparam int RAM_WORDS = 2 ** $bits(adc_acq_data_pkg::cbuf_addr_t);
    // FIFO depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(TFIFO_DEPTH);

    adc_acq_data_pkg::adc_word_t ram [RAM_WORDS];
    adc_acq_data_pkg::cbuf_addr_t wr_ptr;
    adc_acq_data_pkg::cbuf_addr_t rd_addr;
    adc_acq_data_pkg::adc_word_t rd_dat;
    // three older words of the burst
    logic [3*WORD_W-1:0] burst_q;
    adc_acq_data_pkg::cbuf_addr_t tfifo [TFIFO_DEPTH];
    logic [PTR_W-1:0] tfifo_wr_ptr;
    logic [PTR_W-1:0] tfifo_rd_ptr;
    logic [PTR_W:0] tfifo_cnt;
    logic tfifo_push;

    // triggers arriving with the FIFO full are lost
    assign tfifo_push = trig_pulse && (tfifo_cnt != (PTR_W + 1)'(TFIFO_DEPTH));
    assign trig_fifo_empty = (tfifo_cnt == '0);
    // newest word comes straight from the read register
    assign burst_dat = {rd_dat, burst_q};

    always_ff @(posedge clk) begin
        ram[wr_ptr] <= adc_dat;
        rd_dat <= ram[rd_addr];
        // start address reaches back before the trigger
        if (tfifo_push)
            tfifo[tfifo_wr_ptr] <= wr_ptr - adc_acq_data_pkg::cbuf_addr_t'(PRETRIG_WORDS);
        if (init_circ_buf_rd_addr)
            trig_addr <= tfifo[tfifo_rd_ptr];
        // shift right, first latched word ends up lowest
        if (latch_circ_buf_dat)
            burst_q <= {rd_dat, burst_q[3*WORD_W-1:WORD_W]};
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
            rd_addr <= '0;
            tfifo_wr_ptr <= '0;
            tfifo_rd_ptr <= '0;
            tfifo_cnt <= '0;
        end else begin
            // free-running write
            wr_ptr <= wr_ptr + 1'b1;
            if (init_circ_buf_rd_addr)
                rd_addr <= tfifo[tfifo_rd_ptr];
            else if (inc_circ_buf_rd_addr)
                rd_addr <= rd_addr + 1'b1;
            if (tfifo_push)
                tfifo_wr_ptr <= tfifo_wr_ptr + 1'b1;
            if (trig_addr_rd_en)
                tfifo_rd_ptr <= tfifo_rd_ptr + 1'b1;
            if (tfifo_push && !trig_addr_rd_en)
                tfifo_cnt <= tfifo_cnt + 1'b1;
            else if (!tfifo_push && trig_addr_rd_en)
                tfifo_cnt <= tfifo_cnt - 1'b1;
        end
    end

    // the sequencer pops only after seeing an address
    a_no_pop_empty: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        trig_addr_rd_en |-> !trig_fifo_empty);

endmodule

`default_nettype wire

/* verification/adc_acq_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_acq_tb;

    localparam int PRETRIG_WORDS = 16;
    localparam int BURSTS_TYPE1 = 2;
    localparam int BURSTS_TYPE2 = 4;
    localparam int BURSTS_TYPE3 = 8;
    localparam int TFIFO_DEPTH = 4;
    localparam int NUM_CASES = 6;
    // cycles armed before the trigger rises, covers the enable synchronizers
    localparam int ARM_WAIT = 12;
    localparam int HOLD_CYCLES = 16;
    localparam int IDLE_WATCH = 40;
    // slack on the start address, five synchronizer cycles fall inside it
    localparam int ADDR_WINDOW = 8;
    localparam logic [31:0] LFSR_SEED = 32'hca86_cb4d;
    localparam logic [31:0] LFSR_TAPS = 32'hd000_0001;

    logic clk;
    logic adc_acq_full_reset;
    logic acq_enable0;
    logic acq_enable1;
    logic acq_trig;
    logic ddr3_wr_done;
    adc_acq_data_pkg::adc_word_t adc_dat;
    adc_acq_data_pkg::adc_burst_t out_dat;
    logic out_valid;
    logic acq_enabled;
    logic acq_done;
    logic sm_idle;
    adc_acq_data_pkg::fill_num_t fill_cnt;

    // one row per case: name, {enable1, enable0}, trigger, expected bursts
    string case_name [NUM_CASES] = '{"disarmed", "type1", "type2", "armed_no_trig",
                                     "type3", "type1_again"};
    logic [1:0] case_en [NUM_CASES] = '{2'b00, 2'b01, 2'b10, 2'b10, 2'b11, 2'b01};
    logic case_trig [NUM_CASES] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
    int case_bursts [NUM_CASES] = '{0, BURSTS_TYPE1, BURSTS_TYPE2, 0, BURSTS_TYPE3,
                                    BURSTS_TYPE1};
    // ddr3 done delay per row, drawn from the LFSR
    int case_delay [NUM_CASES];

    logic [31:0] lfsr_state;
    int errors;
    int checks;
    int cycle_cnt;
    int timeout_limit;
    int cur_case;
    int fills_done;
    int done_pulses;
    logic done_early;
    logic rst_seen;
    // words seen with out_valid in the current case
    adc_acq_data_pkg::adc_burst_t words [$];

    adc_acq_top #(
        .PRETRIG_WORDS(PRETRIG_WORDS),
        .BURSTS_TYPE1(BURSTS_TYPE1),
        .BURSTS_TYPE2(BURSTS_TYPE2),
        .BURSTS_TYPE3(BURSTS_TYPE3),
        .TFIFO_DEPTH(TFIFO_DEPTH)
    ) dut_i (
        .clk, .adc_acq_full_reset, .acq_enable0, .acq_enable1, .acq_trig,
        .ddr3_wr_done, .adc_dat, .out_dat, .out_valid, .acq_enabled, .acq_done,
        .sm_idle, .fill_cnt
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // adc stream is a word count, word i lands at address i mod 1024
    always @(posedge clk) begin
        rst_seen = adc_acq_full_reset;
        #1;
        if (rst_seen)
            adc_dat = '0;
        else
            adc_dat = adc_dat + 1;
    end

    // collect output words and done pulses mid cycle
    always @(negedge clk) begin
        if (out_valid) begin
            words.push_back(out_dat);
            compare_bit("acq_enabled during fill", 1'b1, acq_enabled);
        end
        if (acq_done) begin
            done_pulses++;
            if (!ddr3_wr_done)
                done_early = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: no progress after %0d cycles in case %s",
                     cycle_cnt, case_name[cur_case]);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one LFSR step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    // leaving WATCH_FOR_TRIG up to DDR3_WAIT
    function automatic int fill_seq_cycles(input int n);
        return 2 + 3 + 4 * n + 2 + 2;
    endfunction

    function automatic adc_acq_data_pkg::adc_burst_t fill_header(
        input adc_acq_ctrl_pkg::fill_type_t ftype, input adc_acq_data_pkg::fill_num_t num);
        adc_acq_data_pkg::adc_burst_t w;
        w = '0;
        w[adc_acq_data_pkg::HDR_TAG_LSB +: 8] = adc_acq_data_pkg::FILL_HDR_TAG;
        w[adc_acq_data_pkg::HDR_TYPE_LSB +: 2] = ftype;
        w[adc_acq_data_pkg::HDR_FILL_LSB +: 16] = num;
        return w;
    endfunction

    function automatic adc_acq_data_pkg::adc_burst_t wfm_header(
        input adc_acq_data_pkg::cbuf_addr_t addr, input adc_acq_data_pkg::burst_cnt_t n);
        adc_acq_data_pkg::adc_burst_t w;
        w = '0;
        w[adc_acq_data_pkg::HDR_TAG_LSB +: 8] = adc_acq_data_pkg::WFM_HDR_TAG;
        w[adc_acq_data_pkg::HDR_ADDR_LSB +: 10] = addr;
        w[adc_acq_data_pkg::HDR_BURSTS_LSB +: 8] = n;
        return w;
    endfunction

    // four consecutive words, first in the low 32 bits
    function automatic adc_acq_data_pkg::adc_burst_t burst_from(
        input adc_acq_data_pkg::adc_word_t first);
        return {first + 32'd3, first + 32'd2, first + 32'd1, first};
    endfunction

    task automatic compare_burst(input string name, input adc_acq_data_pkg::adc_burst_t expected,
                                 input adc_acq_data_pkg::adc_burst_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_fill(input string name, input adc_acq_data_pkg::fill_num_t expected,
                                input adc_acq_data_pkg::fill_num_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_fill_words(input int idx, input adc_acq_data_pkg::adc_word_t trig_base);
        int n;
        adc_acq_data_pkg::cbuf_addr_t hdr_addr;
        adc_acq_data_pkg::cbuf_addr_t addr_lo;
        adc_acq_data_pkg::adc_word_t first;
        adc_acq_data_pkg::adc_word_t word_lo;
        adc_acq_data_pkg::adc_burst_t exp_burst;
        adc_acq_data_pkg::adc_burst_t exp_sum;
        n = case_bursts[idx];
        compare_fill({case_name[idx], " word count"}, adc_acq_data_pkg::fill_num_t'(n + 3),
                     adc_acq_data_pkg::fill_num_t'(words.size()));
        if (words.size() != n + 3)
            return;
        compare_burst({case_name[idx], " fill header"},
                      fill_header(case_en[idx], adc_acq_data_pkg::fill_num_t'(fills_done)),
                      words[0]);
        // start address is write pointer at the trigger minus the pretrigger depth
        word_lo = trig_base - adc_acq_data_pkg::adc_word_t'(PRETRIG_WORDS);
        addr_lo = word_lo[9:0];
        hdr_addr = words[1][adc_acq_data_pkg::HDR_ADDR_LSB +: 10];
        compare_bit({case_name[idx], " trigger address window"}, 1'b1,
                    10'(hdr_addr - addr_lo) <= 10'(ADDR_WINDOW));
        compare_burst({case_name[idx], " waveform header"},
                      wfm_header(hdr_addr, adc_acq_data_pkg::burst_cnt_t'(n)), words[1]);
        first = words[2][31:0];
        compare_bit({case_name[idx], " first word address"}, 1'b1, first[9:0] == hdr_addr);
        compare_bit({case_name[idx], " first word value"}, 1'b1,
                    (first - word_lo) <= 32'(ADDR_WINDOW));
        exp_sum = '0;
        for (int k = 0; k < n; k++) begin
            exp_burst = burst_from(first + 32'(4 * k));
            compare_burst($sformatf("%s burst %0d", case_name[idx], k), exp_burst, words[2 + k]);
            exp_sum = exp_sum ^ exp_burst;
        end
        compare_burst({case_name[idx], " checksum"}, exp_sum, words[n + 2]);
    endtask

    task automatic run_fill(input int idx);
        adc_acq_data_pkg::adc_word_t trig_base;
        int n;
        logic left_done;
        n = case_bursts[idx];
        acq_enable1 = case_en[idx][1];
        acq_enable0 = case_en[idx][0];
        wait_cycles(ARM_WAIT);
        compare_bit({case_name[idx], " acq_enabled while waiting"}, 1'b0, acq_enabled);
        words.delete();
        done_pulses = 0;
        done_early = 1'b0;
        acq_trig = 1'b1;
        // word written at the first edge that sees the trigger
        @(negedge clk);
        trig_base = adc_dat;
        next_cycle();
        while (words.size() < n + 3)
            next_cycle();
        compare_bit({case_name[idx], " no acq_done before ddr3 done"}, 1'b0, done_pulses != 0);
        wait_cycles(case_delay[idx]);
        ddr3_wr_done = 1'b1;
        while (done_pulses == 0)
            next_cycle();
        ddr3_wr_done = 1'b0;
        // trigger still high, so DONE holds
        left_done = 1'b0;
        repeat (HOLD_CYCLES) begin
            next_cycle();
            if (!acq_enabled)
                left_done = 1'b1;
        end
        compare_bit({case_name[idx], " held in DONE while trigger high"}, 1'b0, left_done);
        acq_trig = 1'b0;
        while (acq_enabled)
            next_cycle();
        wait_cycles(2);
        check_fill_words(idx, trig_base);
        fills_done++;
        compare_bit({case_name[idx], " one acq_done pulse"}, 1'b1, done_pulses == 1);
        compare_bit({case_name[idx], " acq_done after ddr3 done"}, 1'b0, done_early);
        compare_fill({case_name[idx], " fill counter"},
                     adc_acq_data_pkg::fill_num_t'(fills_done), fill_cnt);
    endtask

    // no fill expected, either disarmed or no trigger
    task automatic run_quiet(input int idx);
        logic left_idle;
        logic went_enabled;
        acq_enable1 = case_en[idx][1];
        acq_enable0 = case_en[idx][0];
        wait_cycles(ARM_WAIT);
        words.delete();
        done_pulses = 0;
        acq_trig = case_trig[idx];
        left_idle = 1'b0;
        went_enabled = 1'b0;
        repeat (IDLE_WATCH) begin
            next_cycle();
            if (!sm_idle)
                left_idle = 1'b1;
            if (acq_enabled)
                went_enabled = 1'b1;
        end
        acq_trig = 1'b0;
        wait_cycles(8);
        compare_fill({case_name[idx], " word count"}, '0,
                     adc_acq_data_pkg::fill_num_t'(words.size()));
        compare_bit({case_name[idx], " acq_enabled stays low"}, 1'b0, went_enabled);
        compare_bit({case_name[idx], " no acq_done"}, 1'b0, done_pulses != 0);
        if (case_en[idx] == 2'b00)
            compare_bit({case_name[idx], " sm_idle stays high"}, 1'b0, left_idle);
    endtask

    initial begin
        int limit;
        int d;
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        ddr3_wr_done = 1'b0;
        adc_dat = '0;
        errors = 0;
        checks = 0;
        cycle_cnt = 0;
        cur_case = 0;
        fills_done = 0;
        done_pulses = 0;
        done_early = 1'b0;
        lfsr_state = LFSR_SEED;
        // reset, settle time, then every row with its delay and margin
        limit = 60;
        for (int i = 0; i < NUM_CASES; i++) begin
            draw_bits(4, d);
            case_delay[i] = 2 + d;
            limit += ARM_WAIT + IDLE_WATCH + HOLD_CYCLES + fill_seq_cycles(case_bursts[i]);
            limit += case_delay[i] + 40;
        end
        timeout_limit = limit;
        wait_cycles(2);
        adc_acq_full_reset = 1'b0;
        compare_bit("reset sm_idle", 1'b1, sm_idle);
        compare_bit("reset out_valid", 1'b0, out_valid);
        compare_bit("reset acq_done", 1'b0, acq_done);
        compare_bit("reset acq_enabled", 1'b0, acq_enabled);
        compare_fill("reset fill counter", '0, fill_cnt);
        // fill the buffer past the pretrigger window
        wait_cycles(40);
        for (int i = 0; i < NUM_CASES; i++) begin
            cur_case = i;
            if (case_trig[i] && case_en[i] != 2'b00)
                run_fill(i);
            else
                run_quiet(i);
        end
        $display("checks: %0d, errors: %0d, fills: %0d", checks, errors, fills_done);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
